// ==== src/ks10Pkg.sv ====
/*
 * KS-10 console shared definitions
 * Control-ROM field layout, condition codes and APB register map
 */
package ks10Pkg;

   ////////////////////////////////////////
   // Control-ROM word layout
   ////////////////////////////////////////

   localparam int CromWidth     = 16;
   localparam int CromAddrWidth = 3;
   localparam int CondWidth     = 3;
   localparam int SpecSelWidth  = 2;

   // Bit positions, LSB first
   localparam int NextAddrLsb   = 0;
   localparam int CondSelLsb    = 3;
   localparam int SpecEnBit     = 6;
   localparam int SpecSelLsb    = 7;
   localparam int SetHaltBit    = 9;
   localparam int ClrHaltBit    = 10;
   localparam int ClrRunBit     = 11;
   localparam int ClrExecBit    = 12;
   localparam int ClrContBit    = 13;
   localparam int CountStepBit  = 14;

   // Special select code for the console flags
   localparam logic [SpecSelWidth-1:0] SpecSelCons = 2'd1;

   ////////////////////////////////////////
   // Microbranch conditions
   ////////////////////////////////////////

   localparam logic [CondWidth-1:0] CondAlways   = 3'd0;
   localparam logic [CondWidth-1:0] CondRunClear = 3'd1;
   localparam logic [CondWidth-1:0] CondHaltSw   = 3'd2;
   localparam logic [CondWidth-1:0] CondContSet  = 3'd3;
   localparam logic [CondWidth-1:0] CondExecSet  = 3'd4;
   // Running and not halted
   localparam logic [CondWidth-1:0] CondRunning  = 3'd5;

   ////////////////////////////////////////
   // APB register map
   ////////////////////////////////////////

   localparam logic [7:0] RegSwitch = 8'h00;
   localparam logic [7:0] RegStatus = 8'h04;
   localparam logic [7:0] RegSteps  = 8'h08;

   // Switch and status bit positions
   localparam int SwRun  = 0;
   localparam int SwCont = 1;
   localparam int SwExec = 2;
   localparam int SwHalt = 3;

endpackage

// ==== src/controlRom.sv ====
/*
 * Control ROM
 * Eight fixed microwords, read combinationally
 */
`timescale 1ns/10ps

module controlRom
(
   input  logic [ks10Pkg::CromAddrWidth-1:0] addr,
   output logic [ks10Pkg::CromWidth-1:0]     data
);

   localparam int Width = ks10Pkg::CromWidth;
   localparam int Depth = 2 ** ks10Pkg::CromAddrWidth;

   // Next address and condition select of a microword
   function automatic logic [Width-1:0] seqField
   (
      input logic [ks10Pkg::CromAddrWidth-1:0] nextAddr,
      input logic [ks10Pkg::CondWidth-1:0]     cond
   );
      logic [Width-1:0] word;
      word = '0;
      word[ks10Pkg::NextAddrLsb +: ks10Pkg::CromAddrWidth] = nextAddr;
      word[ks10Pkg::CondSelLsb +: ks10Pkg::CondWidth]      = cond;
      return word;
   endfunction

   // Single control bit
   function automatic logic [Width-1:0] oneBit(input int pos);
      logic [Width-1:0] word;
      word = '0;
      word[pos] = 1'b1;
      return word;
   endfunction

   // Special field enabled, console selected
   localparam logic [Width-1:0] ConsSpec =
      oneBit(ks10Pkg::SpecEnBit) | (Width'(ks10Pkg::SpecSelCons) << ks10Pkg::SpecSelLsb);

   ////////////////////////////////////////
   // Microprogram
   ////////////////////////////////////////

   localparam logic [Width-1:0] MicroCode [0:Depth-1] = '{
      // 0: console sample, latch switches
      seqField(3'd1, ks10Pkg::CondAlways) | ConsSpec,
      // 1: idle
      seqField(3'd2, ks10Pkg::CondAlways),
      // 2: halt switch drops RUN
      seqField(3'd3, ks10Pkg::CondHaltSw) | ConsSpec | oneBit(ks10Pkg::ClrRunBit),
      // 3: RUN dropped, enter HALT
      seqField(3'd4, ks10Pkg::CondRunClear) | ConsSpec | oneBit(ks10Pkg::SetHaltBit),
      // 4: continue leaves HALT
      seqField(3'd5, ks10Pkg::CondContSet) | ConsSpec | oneBit(ks10Pkg::ClrHaltBit)
         | oneBit(ks10Pkg::ClrContBit),
      // 5: single step
      seqField(3'd6, ks10Pkg::CondExecSet) | ConsSpec | oneBit(ks10Pkg::ClrExecBit)
         | oneBit(ks10Pkg::CountStepBit),
      // 6: free-running step
      seqField(3'd7, ks10Pkg::CondRunning) | oneBit(ks10Pkg::CountStepBit),
      // 7: back to the top
      seqField(3'd0, ks10Pkg::CondAlways)
   };

   assign data = MicroCode[addr];

endmodule

// ==== src/microSequencer.sv ====
/*
 * Microsequencer
 * Clock-enable divider, microaddress, condition test and step counter
 */
`timescale 1ns/10ps

module microSequencer
#(
   parameter int ClkDiv = 4
)
(
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              consHalt,
   input  logic                              cpuRun,
   input  logic                              cpuCont,
   input  logic                              cpuExec,
   input  logic                              cpuHalt,
   input  logic [ks10Pkg::CromWidth-1:0]     romData,
   output logic [ks10Pkg::CromAddrWidth-1:0] romAddr,
   output logic [ks10Pkg::CromWidth-1:0]     crom,
   output logic                              clken,
   output logic                              swAck,
   output logic [31:0]                       steps
);

   localparam int DivWidth = (ClkDiv > 1) ? $clog2(ClkDiv) : 1;
   localparam logic [DivWidth-1:0] DivLast = DivWidth'(ClkDiv - 1);

   logic [DivWidth-1:0]           divCnt;
   logic [3:0]                    cpuFlags;
   logic [ks10Pkg::CondWidth-1:0] condSel;
   logic                          condTrue;
   logic                          haltReq;

   ////////////////////////////////////////
   // Clock enable
   ////////////////////////////////////////

   // One pulse every ClkDiv cycles
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         divCnt <= '0;
         clken  <= 1'b0;
      end
      else
      begin
         clken <= (divCnt == DivLast);
         if (divCnt == DivLast)
            divCnt <= '0;
         else
            divCnt <= divCnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // Condition test
   ////////////////////////////////////////

   assign cpuFlags[ks10Pkg::SwRun]  = cpuRun;
   assign cpuFlags[ks10Pkg::SwCont] = cpuCont;
   assign cpuFlags[ks10Pkg::SwExec] = cpuExec;
   assign cpuFlags[ks10Pkg::SwHalt] = cpuHalt;

   assign condSel = romData[ks10Pkg::CondSelLsb +: ks10Pkg::CondWidth];

   always_comb
   begin
      case (condSel)
         ks10Pkg::CondAlways:   condTrue = 1'b1;
         // RUN already dropped by a pending halt request
         ks10Pkg::CondRunClear: condTrue = ~cpuFlags[ks10Pkg::SwRun] & haltReq;
         ks10Pkg::CondHaltSw:   condTrue = haltReq;
         ks10Pkg::CondContSet:  condTrue = cpuFlags[ks10Pkg::SwCont];
         ks10Pkg::CondExecSet:  condTrue = cpuFlags[ks10Pkg::SwExec];
         ks10Pkg::CondRunning:
            condTrue = cpuFlags[ks10Pkg::SwRun] & ~cpuFlags[ks10Pkg::SwHalt];
         default:               condTrue = 1'b0;
      endcase
   end

   // False condition turns the word into a no-op
   assign crom = condTrue ? romData : '0;

   // Word 0 is the console sample
   assign swAck = clken & (romAddr == '0);

   ////////////////////////////////////////
   // Microaddress and step count
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         romAddr <= '0;
         haltReq <= 1'b0;
         steps   <= '0;
      end
      else if (clken)
      begin
         // Sequencing ignores the condition
         romAddr <= romData[ks10Pkg::NextAddrLsb +: ks10Pkg::CromAddrWidth];
         // Halt switch kept for the rest of the loop
         if (swAck)
            haltReq <= consHalt;
         if (crom[ks10Pkg::CountStepBit])
            steps <= steps + 32'd1;
      end
   end

endmodule

// ==== src/consoleStatus.sv ====
/*
 * Console status flags
 * RUN, CONT, EXEC and HALT flip-flops under the special-function field
 */
`timescale 1ns/10ps

module consoleStatus
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clken,
   input  logic [ks10Pkg::CromWidth-1:0] crom,
   input  logic                          consRun,
   input  logic                          consCont,
   input  logic                          consExec,
   output logic                          cpuRun,
   output logic                          cpuCont,
   output logic                          cpuExec,
   output logic                          cpuHalt
);

   logic consEn;

   // Special field decode, console select
   assign consEn = crom[ks10Pkg::SpecEnBit]
      & (crom[ks10Pkg::SpecSelLsb +: ks10Pkg::SpecSelWidth] == ks10Pkg::SpecSelCons);

   ////////////////////////////////////////
   // HALT flag
   ////////////////////////////////////////

   // Set wins over clear
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         cpuHalt <= 1'b0;
      else if (clken & consEn)
      begin
         if (crom[ks10Pkg::SetHaltBit])
            cpuHalt <= 1'b1;
         else if (crom[ks10Pkg::ClrHaltBit])
            cpuHalt <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // Switch-driven flags
   ////////////////////////////////////////

   // Switch sets, microcode clears
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cpuRun  <= 1'b0;
         cpuCont <= 1'b0;
         cpuExec <= 1'b0;
      end
      else if (clken & consEn)
      begin
         if (consRun)
            cpuRun <= 1'b1;
         else if (crom[ks10Pkg::ClrRunBit])
            cpuRun <= 1'b0;

         if (consCont)
            cpuCont <= 1'b1;
         else if (crom[ks10Pkg::ClrContBit])
            cpuCont <= 1'b0;

         if (consExec)
            cpuExec <= 1'b1;
         else if (crom[ks10Pkg::ClrExecBit])
            cpuExec <= 1'b0;
      end
   end

endmodule

// ==== src/consoleRegs.sv ====
/*
 * Console register block
 * APB slave for switch pulses, status and step count
 */
`timescale 1ns/10ps

module consoleRegs
(
   input  logic        clk,
   input  logic        rst,
   // APB slave
   input  logic        PSEL,
   input  logic        PENABLE,
   input  logic        PWRITE,
   input  logic [7:0]  PADDR,
   input  logic [31:0] PWDATA,
   output logic [31:0] PRDATA,
   output logic        PREADY,
   output logic        PSLVERR,
   // Sequencer and status side
   input  logic        swAck,
   input  logic        cpuRun,
   input  logic        cpuCont,
   input  logic        cpuExec,
   input  logic        cpuHalt,
   input  logic [31:0] steps,
   output logic        consRun,
   output logic        consCont,
   output logic        consExec,
   output logic        consHalt
);

   logic        wrEn;
   logic        rdEn;
   logic [3:0]  swSet;
   logic [3:0]  swHeld;
   logic [31:0] statusWord;

   ////////////////////////////////////////
   // APB decode
   ////////////////////////////////////////

   // Access phase only, no wait states
   assign wrEn = PSEL & PENABLE & PWRITE;
   assign rdEn = PSEL & PENABLE & ~PWRITE;

   assign PREADY  = 1'b1;
   assign PSLVERR = 1'b0;

   // Bits written as one raise their switch
   assign swSet = (wrEn && (PADDR == ks10Pkg::RegSwitch)) ? PWDATA[3:0] : 4'b0;

   ////////////////////////////////////////
   // Held switches
   ////////////////////////////////////////

   // Cleared at the console sample, new writes still land
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         swHeld <= 4'b0;
      else
         swHeld <= (swAck ? 4'b0 : swHeld) | swSet;
   end

   assign consRun  = swHeld[ks10Pkg::SwRun];
   assign consCont = swHeld[ks10Pkg::SwCont];
   assign consExec = swHeld[ks10Pkg::SwExec];
   assign consHalt = swHeld[ks10Pkg::SwHalt];

   ////////////////////////////////////////
   // Read path
   ////////////////////////////////////////

   // Status in the switch bit layout
   always_comb
   begin
      statusWord = 32'b0;
      statusWord[ks10Pkg::SwRun]  = cpuRun;
      statusWord[ks10Pkg::SwCont] = cpuCont;
      statusWord[ks10Pkg::SwExec] = cpuExec;
      statusWord[ks10Pkg::SwHalt] = cpuHalt;
   end

   // Zero outside a read access
   always_comb
   begin
      PRDATA = 32'b0;
      if (rdEn)
      begin
         case (PADDR)
            ks10Pkg::RegStatus: PRDATA = statusWord;
            ks10Pkg::RegSteps:  PRDATA = steps;
            default:            PRDATA = 32'b0;
         endcase
      end
   end

endmodule

// ==== src/ks10Console.sv ====
/*
 * KS-10 console subsystem top level
 * APB registers, microsequencer, control ROM and status flags
 */
`timescale 1ns/10ps

module ks10Console
#(
   parameter int ClkDiv = 4
)
(
   input  logic        clk,
   input  logic        rst,
   input  logic        PSEL,
   input  logic        PENABLE,
   input  logic        PWRITE,
   input  logic [7:0]  PADDR,
   input  logic [31:0] PWDATA,
   output logic [31:0] PRDATA,
   output logic        PREADY,
   output logic        PSLVERR
);

   // Switch pulses and acknowledge
   logic consRun;
   logic consCont;
   logic consExec;
   logic consHalt;
   logic swAck;

   // Status flags
   logic cpuRun;
   logic cpuCont;
   logic cpuExec;
   logic cpuHalt;

   // Microcode path
   logic [ks10Pkg::CromAddrWidth-1:0] romAddr;
   logic [ks10Pkg::CromWidth-1:0]     romData;
   logic [ks10Pkg::CromWidth-1:0]     crom;
   logic                              clken;
   logic [31:0]                       steps;

   consoleRegs consoleRegs_inst (
      .clk(clk), .rst(rst),
      .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA),
      .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
      .swAck(swAck), .cpuRun(cpuRun), .cpuCont(cpuCont), .cpuExec(cpuExec),
      .cpuHalt(cpuHalt), .steps(steps),
      .consRun(consRun), .consCont(consCont), .consExec(consExec), .consHalt(consHalt)
   );

   microSequencer #(.ClkDiv(ClkDiv)) microSequencer_inst (
      .clk(clk), .rst(rst), .consHalt(consHalt),
      .cpuRun(cpuRun), .cpuCont(cpuCont), .cpuExec(cpuExec), .cpuHalt(cpuHalt),
      .romData(romData), .romAddr(romAddr), .crom(crom), .clken(clken),
      .swAck(swAck), .steps(steps)
   );

   controlRom controlRom_inst (.addr(romAddr), .data(romData));

   consoleStatus consoleStatus_inst (
      .clk(clk), .rst(rst), .clken(clken), .crom(crom),
      .consRun(consRun), .consCont(consCont), .consExec(consExec),
      .cpuRun(cpuRun), .cpuCont(cpuCont), .cpuExec(cpuExec), .cpuHalt(cpuHalt)
   );

endmodule

// ==== test/ks10Console_sva.sv ====
/*
 * KS-10 console assertions
 * Flags in reset, APB phase order and EXEC lifetime
 */
`timescale 1ns/10ps

module ks10Console_sva
#(
   parameter int ClkDiv = 4
)
(
   input logic clk,
   input logic rst,
   input logic PSEL,
   input logic PENABLE,
   input logic cpuRun,
   input logic cpuCont,
   input logic cpuExec,
   input logic cpuHalt
);

   localparam int LoopCycles = 8 * ClkDiv;

   // Cycles EXEC has stayed set
   int execAge;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         execAge <= 0;
      else if (cpuExec)
         execAge <= execAge + 1;
      else
         execAge <= 0;
   end

   flagsLowInReset: assert property (@(posedge clk)
      rst |-> !(cpuRun || cpuCont || cpuExec || cpuHalt))
      else $error("Status flags set during reset");

   // Setup phase is always followed by the access phase
   setupThenAccess: assert property (@(posedge clk) disable iff (rst)
      (PSEL && !PENABLE) |=> (PSEL && PENABLE))
      else $error("APB setup phase not followed by access phase");

   enableNeedsSelect: assert property (@(posedge clk) disable iff (rst)
      PENABLE |-> PSEL)
      else $error("PENABLE high without PSEL");

   // Step word clears EXEC in the same loop
   execWithinLoop: assert property (@(posedge clk) disable iff (rst)
      execAge <= LoopCycles)
      else $error("EXEC flag held longer than one microcode loop");

endmodule

bind ks10Console ks10Console_sva #(.ClkDiv(ClkDiv)) ks10Console_sva_inst (
   .clk(clk), .rst(rst), .PSEL(PSEL), .PENABLE(PENABLE),
   .cpuRun(cpuRun), .cpuCont(cpuCont), .cpuExec(cpuExec), .cpuHalt(cpuHalt)
);

// ==== test/ks10ConsoleTb.sv ====
/*
 * KS-10 console testbench
 * APB console switches checked against a per-loop reference model
 */
`timescale 1ns/10ps

module ks10ConsoleTb;

   localparam int ClkDiv       = 4;
   localparam int ClkPeriod    = 100;
   localparam int DriveDelay   = 10;
   localparam int ResetCycles  = 10;
   localparam int LoopCycles   = 8 * ClkDiv;
   // Sample word within one loop, its effects done one loop later
   localparam int SettleCycles = 2 * LoopCycles + ClkDiv;
   localparam int ReadyLimit   = 16;
   // Random loop counts add up to at most 8 + 5 + 5
   localparam int MaxLoops     = 18;
   localparam int ApbOps       = 24;
   localparam int WatchdogCycles = ResetCycles + 5 * SettleCycles + MaxLoops * LoopCycles
      + ApbOps * (4 + ReadyLimit) + 200;

   logic        clk;
   logic        rst;
   logic        PSEL;
   logic        PENABLE;
   logic        PWRITE;
   logic [7:0]  PADDR;
   logic [31:0] PWDATA;
   logic [31:0] PRDATA;
   logic        PREADY;
   logic        PSLVERR;

   int          errorCount = 0;
   int          checkCount = 0;
   logic [3:0]  modelFlags;
   logic [31:0] modelSteps;

   // Pending checks for the comparator
   string       nameQ[$];
   logic [31:0] gotQ[$];
   logic [31:0] expQ[$];
   int          tolQ[$];

   ks10Console #(.ClkDiv(ClkDiv)) ks10Console_inst (
      .clk(clk), .rst(rst),
      .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA),
      .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR)
   );

   initial
   begin
      clk = 1'b0;
      forever #(ClkPeriod / 2) clk = ~clk;
   end

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // Net effect of one pass through the microcode loop
   function automatic logic [35:0] loopModel
   (
      input logic [3:0]  flags,
      input logic [3:0]  sw,
      input logic [31:0] stepCount
   );
      logic        run;
      logic        cont;
      logic        exec;
      logic        halt;
      logic [31:0] count;
      logic [3:0]  status;
      // Console sample latches set switches
      run   = flags[ks10Pkg::SwRun] | sw[ks10Pkg::SwRun];
      cont  = flags[ks10Pkg::SwCont] | sw[ks10Pkg::SwCont];
      exec  = flags[ks10Pkg::SwExec] | sw[ks10Pkg::SwExec];
      halt  = flags[ks10Pkg::SwHalt];
      count = stepCount;
      // Halt switch stops the processor
      if (sw[ks10Pkg::SwHalt])
      begin
         run  = 1'b0;
         halt = 1'b1;
      end
      if (cont)
      begin
         halt = 1'b0;
         cont = 1'b0;
      end
      // Single step
      if (exec)
      begin
         count = count + 32'd1;
         exec  = 1'b0;
      end
      if (run && !halt)
         count = count + 32'd1;
      status = 4'b0;
      status[ks10Pkg::SwRun]  = run;
      status[ks10Pkg::SwCont] = cont;
      status[ks10Pkg::SwExec] = exec;
      status[ks10Pkg::SwHalt] = halt;
      return {count, status};
   endfunction

   function automatic logic [3:0] switchBit(input int pos);
      logic [3:0] sw;
      sw = 4'b0;
      sw[pos] = 1'b1;
      return sw;
   endfunction

   ////////////////////////////////////////
   // APB driver
   ////////////////////////////////////////

   task automatic apbTransfer
   (
      input  logic        write,
      input  logic [7:0]  addr,
      input  logic [31:0] wdata,
      output logic [31:0] rdata
   );
      int waits;
      waits = 0;
      @(posedge clk);
      #DriveDelay;
      PSEL    = 1'b1;
      PENABLE = 1'b0;
      PWRITE  = write;
      PADDR   = addr;
      PWDATA  = wdata;
      @(posedge clk);
      #DriveDelay;
      PENABLE = 1'b1;
      // Access phase sampled mid-cycle
      @(negedge clk);
      while (!PREADY && waits < ReadyLimit)
      begin
         waits++;
         @(negedge clk);
      end
      rdata = PRDATA;
      if (!PREADY)
      begin
         errorCount++;
         $display("APB transfer at 0x%02h never saw PREADY high", addr);
      end
      if (PSLVERR)
      begin
         errorCount++;
         $display("APB transfer at 0x%02h returned a slave error", addr);
      end
      @(posedge clk);
      #DriveDelay;
      PSEL    = 1'b0;
      PENABLE = 1'b0;
      PWRITE  = 1'b0;
   endtask

   task automatic postCheck(input string name, input logic [31:0] got,
                            input logic [31:0] exp, input int tol);
      nameQ.push_back(name);
      gotQ.push_back(got);
      expQ.push_back(exp);
      tolQ.push_back(tol);
   endtask

   // Switch write, model update, then wait for the loop to act
   task automatic switchAndSettle(input logic [3:0] sw);
      logic [31:0] unused;
      logic [35:0] next;
      apbTransfer(1'b1, ks10Pkg::RegSwitch, {28'b0, sw}, unused);
      next = loopModel(modelFlags, sw, modelSteps);
      modelFlags = next[3:0];
      modelSteps = next[35:4];
      repeat (SettleCycles) @(posedge clk);
   endtask

   task automatic idleLoops(input int loops);
      logic [35:0] next;
      repeat (loops * LoopCycles) @(posedge clk);
      for (int i = 0; i < loops; i++)
      begin
         next = loopModel(modelFlags, 4'b0, modelSteps);
         modelFlags = next[3:0];
         modelSteps = next[35:4];
      end
   endtask

   task automatic checkStatus(input string name);
      logic [31:0] value;
      apbTransfer(1'b0, ks10Pkg::RegStatus, 32'b0, value);
      postCheck(name, value, {28'b0, modelFlags}, 0);
   endtask

   task automatic checkSteps(input string name, input int tol, output logic [31:0] value);
      apbTransfer(1'b0, ks10Pkg::RegSteps, 32'b0, value);
      postCheck(name, value, modelSteps, tol);
   endtask

   ////////////////////////////////////////
   // Comparator
   ////////////////////////////////////////

   always @(posedge clk)
   begin : compare
      string       name;
      logic [31:0] got;
      logic [31:0] exp;
      logic [31:0] diff;
      int          tol;
      while (gotQ.size() > 0)
      begin
         name = nameQ.pop_front();
         got  = gotQ.pop_front();
         exp  = expQ.pop_front();
         tol  = tolQ.pop_front();
         diff = (got > exp) ? got - exp : exp - got;
         checkCount++;
         if (diff > 32'(tol))
         begin
            errorCount++;
            $display("Error at %0t: %s got 0x%08h, expected 0x%08h (tolerance %0d)",
                     $time, name, got, exp, tol);
         end
      end
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial
   begin : stimulus
      logic [31:0] rdData;
      rst     = 1'b1;
      PSEL    = 1'b0;
      PENABLE = 1'b0;
      PWRITE  = 1'b0;
      PADDR   = 8'h00;
      PWDATA  = 32'h0;
      modelFlags = 4'b0;
      modelSteps = 32'd0;
      void'($urandom(32'h4492));
      repeat (ResetCycles) @(posedge clk);
      #DriveDelay;
      rst = 1'b0;

      checkStatus("status after reset");
      checkSteps("steps after reset", 0, rdData);

      // RUN, count grows once per loop
      switchAndSettle(switchBit(ks10Pkg::SwRun));
      checkStatus("status after RUN");
      checkSteps("steps after RUN", 1, rdData);
      modelSteps = rdData;
      idleLoops(3 + int'($urandom % 6));
      checkSteps("steps while running", 1, rdData);
      modelSteps = rdData;
      checkStatus("status while running");

      // HALT drops RUN and freezes the count
      switchAndSettle(switchBit(ks10Pkg::SwHalt));
      checkStatus("status after HALT");
      checkSteps("steps after HALT", 1, rdData);
      modelSteps = rdData;
      idleLoops(2 + int'($urandom % 4));
      checkSteps("steps while halted", 0, rdData);

      // Single step while halted
      switchAndSettle(switchBit(ks10Pkg::SwExec));
      checkStatus("status after EXEC");
      checkSteps("steps after EXEC", 0, rdData);

      // CONT leaves HALT, RUN again resumes counting
      switchAndSettle(switchBit(ks10Pkg::SwCont));
      checkStatus("status after CONT");
      checkSteps("steps after CONT", 0, rdData);
      switchAndSettle(switchBit(ks10Pkg::SwRun));
      checkStatus("status after second RUN");
      checkSteps("steps after second RUN", 1, rdData);
      modelSteps = rdData;
      idleLoops(2 + int'($urandom % 4));
      checkSteps("steps after resume", 1, rdData);

      // Comparator drains the last checks
      repeat (2) @(posedge clk);
      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   initial
   begin : watchdog
      repeat (WatchdogCycles) @(posedge clk);
      $display("Watchdog expired after %0d cycles, test sequence did not finish",
               WatchdogCycles);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== list.f ====
src/ks10Pkg.sv
src/controlRom.sv
src/microSequencer.sv
src/consoleStatus.sv
src/consoleRegs.sv
src/ks10Console.sv
test/ks10Console_sva.sv
test/ks10ConsoleTb.sv

// ==== Makefile ====
# Verilator simulation of the KS-10 console subsystem

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module ks10ConsoleTb -f list.f
	./obj_dir/Vks10ConsoleTb > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "RESULT: FAIL" sim.log; then exit 1; fi; \
	exit $$status

clean:
	rm -rf obj_dir sim.log
